/* include/slink_cfg.svh */
// Slink monitor build settings
`ifndef SLINK_CFG_SVH
`define SLINK_CFG_SVH

// ----------------------------------------
// Fault count thresholds
// ----------------------------------------
// Count at which each fault flag sets
`define SLINK_LEN_ERR_THRESHOLD   8'd4
`define SLINK_TICK_ERR_THRESHOLD  8'd4
`define SLINK_CRC_ERR_THRESHOLD   8'd4
// Delay episodes before the delay flag holds on its own
`define SLINK_DELAY_ERR_THRESHOLD 8'd4

// Clean packets on every check before all counters clear
`define SLINK_PKT_OK_THRESHOLD    8'd8

// ----------------------------------------
// Timing and bus
// ----------------------------------------
// Idle cycles after eop before the delay fault rises
`define SLINK_GAP_LIMIT           16'd64
// Wishbone word address width
`define SLINK_WB_AW               3

`endif

/* source/slink_pkg.sv */
// Slink monitor shared types
package slink_pkg;

    // One received byte with framing marks
    typedef struct packed {
        logic       valid;
        logic       sop;
        logic       eop;
        logic [7:0] data;
    } slink_rx_byte_t;

    // Per-packet result, errors only meaningful with done
    typedef struct packed {
        logic done;
        logic len_err;
        logic tick_err;
        logic crc_err;
    } slink_pkt_status_t;

    // Saturating fault counters
    typedef struct packed {
        logic [7:0] len_cnt;
        logic [7:0] tick_cnt;
        logic [7:0] crc_cnt;
        logic [7:0] delay_cnt;
    } slink_diag_cnt_t;

    // Fault levels, brk lands in bit 0 of the status word
    typedef struct packed {
        logic link_err;
        logic delay;
        logic crc;
        logic tick;
        logic len;
        logic brk;
    } slink_fault_t;

endpackage

/* source/slink_crc8.sv */
// Running CRC-8 register
`timescale 1ns/1ps

module slink_crc8 (
    input  logic       clk_125m,
    input  logic       rst_125m,
    input  logic       init,
    input  logic       en,
    input  logic [7:0] data,
    output logic [7:0] crc
);

    logic [7:0] crc_base;

    // Poly 0x07, MSB first
    function automatic logic [7:0] crc8_byte(input logic [7:0] crc_in, input logic [7:0] d);
        logic [7:0] c;
        c = crc_in ^ d;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ({c[6:0], 1'b0} ^ 8'h07) : {c[6:0], 1'b0};
        end
        return c;
    endfunction

    // Init together with en folds the byte into a fresh zero
    assign crc_base = init ? 8'h00 : crc;

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            crc <= 8'h00;
        end else if (en) begin
            crc <= crc8_byte(crc_base, data);
        end else if (init) begin
            crc <= 8'h00;
        end
    end

endmodule

/* source/slink_rx_fsm.sv */
// Slink packet parser
`timescale 1ns/1ps

module slink_rx_fsm (
    input  logic                         clk_125m,
    input  logic                         rst_125m,
    input  slink_pkg::slink_rx_byte_t    rx,
    output slink_pkg::slink_pkt_status_t pkt_status
);
    import slink_pkg::*;

    // State names the last byte kind taken
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_TICK,
        ST_PAYLOAD,
        ST_CHECK
    } state_t;

    state_t            state;
    slink_pkt_status_t status_q;
    logic [7:0]        len_q;
    logic [8:0]        pay_cnt;
    logic [7:0]        exp_tick;
    logic              tick_seen;
    logic              tick_bad;
    logic [7:0]        crc;
    logic              crc_en;
    logic              in_pkt;
    logic              byte_sop;
    logic              byte_eop;
    logic              byte_mid;

    assign in_pkt   = (state == ST_HEADER) || (state == ST_TICK) || (state == ST_PAYLOAD);
    assign byte_sop = rx.valid && rx.sop;
    assign byte_eop = rx.valid && rx.eop && !rx.sop;
    assign byte_mid = rx.valid && !rx.sop && !rx.eop;
    // CRC byte itself stays out of the sum
    assign crc_en   = rx.valid && !rx.eop;

    slink_crc8 u_slink_crc8 (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .init     (byte_sop),
        .en       (crc_en),
        .data     (rx.data),
        .crc      (crc)
    );

    // Header length
    always_ff @(posedge clk_125m) begin
        if (byte_sop) begin
            len_q <= rx.data;
        end
    end

    // ----------------------------------------
    // Parser and status
    // ----------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            state     <= ST_IDLE;
            status_q  <= '0;
            pay_cnt   <= '0;
            exp_tick  <= '0;
            tick_seen <= 1'b0;
            tick_bad  <= 1'b0;
        end else begin
            status_q <= '0;
            if (byte_sop) begin
                // Sop mid-packet closes the old one as a length error
                status_q.done     <= in_pkt || rx.eop;
                status_q.len_err  <= in_pkt || rx.eop;
                status_q.tick_err <= in_pkt && tick_bad;
                pay_cnt           <= '0;
                tick_bad          <= 1'b0;
                state             <= rx.eop ? ST_CHECK : ST_HEADER;
            end else if (in_pkt && byte_eop) begin
                status_q.done     <= 1'b1;
                status_q.len_err  <= (state == ST_HEADER) || (pay_cnt != {1'b0, len_q});
                status_q.tick_err <= tick_bad;
                status_q.crc_err  <= (crc != rx.data);
                state             <= ST_CHECK;
            end else if (in_pkt && byte_mid) begin
                if (state == ST_HEADER) begin
                    // Any tick accepted before the first one
                    tick_bad  <= tick_seen && (rx.data != exp_tick);
                    exp_tick  <= rx.data + 8'd1;
                    tick_seen <= 1'b1;
                    state     <= ST_TICK;
                end else begin
                    // Sticks at 256 so long packets still mismatch
                    if (!pay_cnt[8]) begin
                        pay_cnt <= pay_cnt + 9'd1;
                    end
                    state <= ST_PAYLOAD;
                end
            end else if (state == ST_CHECK) begin
                state <= ST_IDLE;
            end
        end
    end

    assign pkt_status = status_q;

    // Errors only ever ride on a done pulse
    assert property (@(posedge clk_125m) disable iff (!rst_125m)
        (pkt_status.len_err || pkt_status.tick_err || pkt_status.crc_err) |-> pkt_status.done)
        else $error("slink_rx_fsm: error flag without done");

endmodule

/* source/slink_gap_timer.sv */
// Slink inter-packet gap timer
`timescale 1ns/1ps
`include "slink_cfg.svh"

module slink_gap_timer (
    input  logic                      clk_125m,
    input  logic                      rst_125m,
    input  slink_pkg::slink_rx_byte_t rx,
    output logic                      delay_err
);

    localparam logic [15:0] GAP_LIMIT = `SLINK_GAP_LIMIT;

    logic [15:0] gap_cnt;
    logic        armed;

    // Armed by eop, silent until the first packet ends
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            gap_cnt   <= '0;
            armed     <= 1'b0;
            delay_err <= 1'b0;
        end else if (rx.valid && rx.eop) begin
            gap_cnt   <= 16'd1;
            armed     <= 1'b1;
            delay_err <= 1'b0;
        end else if (rx.valid && rx.sop) begin
            gap_cnt   <= '0;
            armed     <= 1'b0;
            delay_err <= 1'b0;
        end else if (armed) begin
            // Stops at the limit, fault holds until sop
            if (gap_cnt == GAP_LIMIT - 16'd1) begin
                delay_err <= 1'b1;
                armed     <= 1'b0;
            end
            gap_cnt <= gap_cnt + 16'd1;
        end
    end

    assert property (@(posedge clk_125m) disable iff (!rst_125m)
        (rx.valid && rx.sop) |=> !delay_err)
        else $error("slink_gap_timer: delay_err high after sop");

endmodule

/* source/slink_diag.sv */
// Slink fault diagnosis
`timescale 1ns/1ps
`include "slink_cfg.svh"

module slink_diag (
    input  logic                         clk_125m,
    input  logic                         rst_125m,
    input  slink_pkg::slink_pkt_status_t pkt_status,
    input  logic                         delay_err,
    input  logic                         link_break,
    output slink_pkg::slink_diag_cnt_t   cnt,
    output slink_pkg::slink_fault_t      fault,
    output logic                         link_err
);

    // Kinds 0 len, 1 tick, 2 crc, 3 delay
    localparam int NUM_KIND = 4;
    localparam logic [7:0] ERR_THR [NUM_KIND] = '{
        `SLINK_LEN_ERR_THRESHOLD,
        `SLINK_TICK_ERR_THRESHOLD,
        `SLINK_CRC_ERR_THRESHOLD,
        `SLINK_DELAY_ERR_THRESHOLD
    };
    localparam logic [7:0] OK_THR = `SLINK_PKT_OK_THRESHOLD;

    logic [7:0]          err_cnt [NUM_KIND];
    logic [7:0]          ok_cnt  [NUM_KIND];
    logic [NUM_KIND-1:0] err_inc;
    logic [NUM_KIND-1:0] ok_rst;
    logic [NUM_KIND-1:0] flag;
    logic                delay_err_d1;
    logic                delay_fall;
    logic                all_ok;
    logic                err_clear;
    logic                err_any;
    logic                err_d1;
    logic                err_d2;

    // ----------------------------------------
    // Events
    // ----------------------------------------
    assign delay_fall = delay_err_d1 && !delay_err;
    assign err_inc    = {delay_fall,
                         pkt_status.done && pkt_status.crc_err,
                         pkt_status.done && pkt_status.tick_err,
                         pkt_status.done && pkt_status.len_err};
    // Delay good run breaks while the gap fault is up
    assign ok_rst     = {delay_err, err_inc[2:0]};

    // ----------------------------------------
    // Fault counters and flags
    // ----------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            for (int i = 0; i < NUM_KIND; i++) begin
                err_cnt[i] <= '0;
            end
            flag         <= '0;
            delay_err_d1 <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_KIND; i++) begin
                // A fresh error outranks a pending clear
                if (err_inc[i] && err_cnt[i] != 8'hff) begin
                    err_cnt[i] <= err_cnt[i] + 8'd1;
                end else if (err_clear) begin
                    err_cnt[i] <= '0;
                end
                flag[i] <= (err_cnt[i] >= ERR_THR[i]);
            end
            // Live gap fault also holds the delay flag
            flag[3]      <= (err_cnt[3] >= ERR_THR[3]) || delay_err;
            delay_err_d1 <= delay_err;
        end
    end

    // ----------------------------------------
    // Good-packet clearing
    // ----------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            for (int i = 0; i < NUM_KIND; i++) begin
                ok_cnt[i] <= '0;
            end
            err_clear <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_KIND; i++) begin
                if (ok_rst[i]) begin
                    ok_cnt[i] <= '0;
                end else if (pkt_status.done && ok_cnt[i] < OK_THR) begin
                    ok_cnt[i] <= ok_cnt[i] + 8'd1;
                end
            end
            // Any error this cycle holds the clear back
            err_clear <= all_ok && !(|ok_rst);
        end
    end

    always_comb begin
        all_ok = 1'b1;
        for (int i = 0; i < NUM_KIND; i++) begin
            all_ok = all_ok && (ok_cnt[i] >= OK_THR);
        end
    end

    // ----------------------------------------
    // Link error over two stages
    // ----------------------------------------
    assign err_any = link_break || flag[0] || flag[1] || flag[2] || delay_err;

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            err_d1 <= 1'b0;
            err_d2 <= 1'b0;
        end else begin
            err_d1 <= err_any;
            err_d2 <= err_d1;
        end
    end

    assign link_err       = err_d2;
    assign cnt.len_cnt    = err_cnt[0];
    assign cnt.tick_cnt   = err_cnt[1];
    assign cnt.crc_cnt    = err_cnt[2];
    assign cnt.delay_cnt  = err_cnt[3];
    assign fault.brk      = link_break;
    assign fault.len      = flag[0];
    assign fault.tick     = flag[1];
    assign fault.crc      = flag[2];
    assign fault.delay    = flag[3];
    assign fault.link_err = err_d2;

    // Saturated counters only leave 255 through the clear
    for (genvar g = 0; g < NUM_KIND; g++) begin : g_sat_chk
        assert property (@(posedge clk_125m) disable iff (!rst_125m)
            (err_cnt[g] == 8'hff && !err_clear) |=> (err_cnt[g] == 8'hff))
            else $error("slink_diag: counter %0d left saturation", g);
    end

endmodule

/* source/slink_wb_regs.sv */
// Slink status registers on Wishbone
`timescale 1ns/1ps
`include "slink_cfg.svh"

module slink_wb_regs (
    input  logic                       clk_125m,
    input  logic                       rst_125m,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`SLINK_WB_AW-1:0]    wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    input  slink_pkg::slink_diag_cnt_t cnt,
    input  slink_pkg::slink_fault_t    fault
);

    logic [31:0] rd_word;
    logic        wb_req;

    // New request only while ack is low
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            `SLINK_WB_AW'(0): rd_word[$bits(fault)-1:0] = fault;
            `SLINK_WB_AW'(1): rd_word[7:0] = cnt.len_cnt;
            `SLINK_WB_AW'(2): rd_word[7:0] = cnt.tick_cnt;
            `SLINK_WB_AW'(3): rd_word[7:0] = cnt.crc_cnt;
            `SLINK_WB_AW'(4): rd_word[7:0] = cnt.delay_cnt;
            default:          rd_word = '0;
        endcase
    end

    // Single-cycle ack, one low cycle between
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Writes are taken and dropped, data returns zero
    always_ff @(posedge clk_125m) begin
        if (wb_req) begin
            wb_dat_r <= wb_we ? 32'd0 : rd_word;
        end
    end

    assert property (@(posedge clk_125m) disable iff (!rst_125m)
        wb_ack |=> !wb_ack)
        else $error("slink_wb_regs: ack high two cycles");

    // Master side, request held steady up to ack
    assert property (@(posedge clk_125m) disable iff (!rst_125m)
        wb_req |=> (wb_cyc && wb_stb && $stable({wb_we, wb_adr, wb_dat_w})))
        else $error("slink_wb_regs: request changed before ack");

endmodule

/* source/slink_monitor_top.sv */
// Slink receive monitor
`timescale 1ns/1ps
`include "slink_cfg.svh"

module slink_monitor_top (
    input  logic                      clk_125m,
    input  logic                      rst_125m,
    input  slink_pkg::slink_rx_byte_t rx,
    input  logic                      link_break,
    output logic                      link_err,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`SLINK_WB_AW-1:0]   wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack
);
    import slink_pkg::*;

    slink_pkt_status_t pkt_status;
    logic              delay_err;
    slink_diag_cnt_t   cnt;
    slink_fault_t      fault;

    // Packet checks
    slink_rx_fsm u_slink_rx_fsm (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .rx         (rx),
        .pkt_status (pkt_status)
    );

    slink_gap_timer u_slink_gap_timer (
        .clk_125m  (clk_125m),
        .rst_125m  (rst_125m),
        .rx        (rx),
        .delay_err (delay_err)
    );

    // Counting and link error
    slink_diag u_slink_diag (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .pkt_status (pkt_status),
        .delay_err  (delay_err),
        .link_break (link_break),
        .cnt        (cnt),
        .fault      (fault),
        .link_err   (link_err)
    );

    // Host access
    slink_wb_regs u_slink_wb_regs (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cnt      (cnt),
        .fault    (fault)
    );

endmodule

/* bench/slink_monitor_tb.sv */
// Slink monitor testbench
`timescale 1ns/1ps
`include "slink_cfg.svh"

module slink_monitor_tb;
    import slink_pkg::*;

    // One table row with stimulus then expected readback
    typedef struct packed {
        logic [7:0] len;
        logic [7:0] tick_off;
        logic       crc_bad;
        logic       len_lie;
        logic       cut;
        logic [7:0] gap;
        logic [7:0] exp_len;
        logic [7:0] exp_tick;
        logic [7:0] exp_crc;
        logic [7:0] exp_delay;
        logic [7:0] exp_fault;
    } row_t;

    logic                    clk_125m = 1'b0;
    logic                    rst_125m;
    slink_rx_byte_t          rx;
    logic                    link_break;
    logic                    link_err;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`SLINK_WB_AW-1:0] wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;

    row_t       rows [0:63];
    int         num_rows = 0;
    int         errors = 0;
    int         checks = 0;
    int         budget = 0;
    integer     seed = 32'hc463_42d7;
    // First tick is free so start somewhere odd
    logic [7:0] next_tick = 8'h3a;

    always #4 clk_125m = ~clk_125m;

    slink_monitor_top u_slink_monitor_top (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .rx         (rx),
        .link_break (link_break),
        .link_err   (link_err),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------
    // Bit-serial CRC-8 with poly 0x07 and MSB first
    function automatic logic [7:0] crc8_next(input logic [7:0] crc_in, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc_in;
        for (int k = 7; k >= 0; k--) begin
            fb = c[7] ^ b[k];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    task automatic add_row(input int len, input int toff, input int crc_bad, input int lie,
                           input int cut, input int gap, input int e_len, input int e_tick,
                           input int e_crc, input int e_dly, input int e_fault);
        row_t r;
        r.len       = len[7:0];
        r.tick_off  = toff[7:0];
        r.crc_bad   = crc_bad[0];
        r.len_lie   = lie[0];
        r.cut       = cut[0];
        r.gap       = gap[7:0];
        r.exp_len   = e_len[7:0];
        r.exp_tick  = e_tick[7:0];
        r.exp_crc   = e_crc[7:0];
        r.exp_delay = e_dly[7:0];
        r.exp_fault = e_fault[7:0];
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic compare_value(input string name, input int step,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at step %0d: got 0x%0h, expected 0x%0h", name, step, got, exp);
        end
    endtask

    // Header, tick, payload and CRC bytes between falling edges
    task automatic send_packet(input row_t r);
        logic [7:0] pkt [0:15];
        logic [7:0] crc;
        int         n;
        pkt[0]    = r.len;
        pkt[1]    = next_tick + r.tick_off;
        // Expected tick always follows the one sent
        next_tick = pkt[1] + 8'd1;
        n         = 2 + r.len + r.len_lie;
        for (int k = 2; k < n; k++) begin
            pkt[k] = 8'($random(seed));
        end
        crc = 8'h00;
        for (int k = 0; k < n; k++) begin
            crc = crc8_next(crc, pkt[k]);
        end
        // Cut packet stops before its CRC byte
        if (!r.cut) begin
            pkt[n] = r.crc_bad ? ~crc : crc;
            n++;
        end
        for (int k = 0; k < n; k++) begin
            rx.valid = 1'b1;
            rx.sop   = (k == 0);
            rx.eop   = !r.cut && (k == n - 1);
            rx.data  = pkt[k];
            @(negedge clk_125m);
        end
        rx = '0;
    endtask

    // Classic cycle held one edge past ack
    task automatic wb_access(input logic we, input int adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int wait_cnt;
        wait_cnt = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[`SLINK_WB_AW-1:0];
        wb_dat_w = wdata;
        @(negedge clk_125m);
        while (!wb_ack && wait_cnt < 16) begin
            @(negedge clk_125m);
            wait_cnt++;
        end
        if (!wb_ack) begin
            errors++;
            $display("No Wishbone ack for address %0d", adr);
        end
        rdata = wb_dat_r;
        @(negedge clk_125m);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Write first then read back every register
    task automatic check_row(input int idx, input row_t r);
        logic [31:0] rd;
        wb_access(1'b1, 1 + idx % 4, $random(seed), rd);
        wb_access(1'b0, 0, 32'd0, rd);
        compare_value("fault", idx, rd, {24'd0, r.exp_fault});
        wb_access(1'b0, 1, 32'd0, rd);
        compare_value("len_cnt", idx, rd, {24'd0, r.exp_len});
        wb_access(1'b0, 2, 32'd0, rd);
        compare_value("tick_cnt", idx, rd, {24'd0, r.exp_tick});
        wb_access(1'b0, 3, 32'd0, rd);
        compare_value("crc_cnt", idx, rd, {24'd0, r.exp_crc});
        wb_access(1'b0, 4, 32'd0, rd);
        compare_value("delay_cnt", idx, rd, {24'd0, r.exp_delay});
        compare_value("link_err", idx, {31'd0, link_err}, {31'd0, r.exp_fault[5]});
    endtask

    // Break alone takes two stages each way
    task automatic check_link_break();
        logic [31:0] rd;
        link_break = 1'b1;
        @(negedge clk_125m);
        compare_value("link_err", 100, {31'd0, link_err}, 32'd0);
        @(negedge clk_125m);
        compare_value("link_err", 101, {31'd0, link_err}, 32'd1);
        // brk in bit 0 and link_err in bit 5
        wb_access(1'b0, 0, 32'd0, rd);
        compare_value("fault", 102, rd, 32'h21);
        link_break = 1'b0;
        @(negedge clk_125m);
        compare_value("link_err", 103, {31'd0, link_err}, 32'd1);
        @(negedge clk_125m);
        compare_value("link_err", 104, {31'd0, link_err}, 32'd0);
        wb_access(1'b0, 0, 32'd0, rd);
        compare_value("fault", 105, rd, 32'h00);
    endtask

    // Unmapped addresses then counters after a write
    task automatic check_bus_map();
        logic [31:0] rd;
        logic [7:0]  exp_cnt [1:4];
        // Counters still hold what the last row left
        exp_cnt[1] = rows[num_rows-1].exp_len;
        exp_cnt[2] = rows[num_rows-1].exp_tick;
        exp_cnt[3] = rows[num_rows-1].exp_crc;
        exp_cnt[4] = rows[num_rows-1].exp_delay;
        for (int a = 5; a < 8; a++) begin
            wb_access(1'b0, a, 32'd0, rd);
            compare_value("wb_dat_r", 200 + a, rd, 32'd0);
        end
        wb_access(1'b1, 3, 32'hffff_ffff, rd);
        for (int a = 1; a < 5; a++) begin
            wb_access(1'b0, a, 32'd0, rd);
            compare_value("wb_dat_r", 210 + a, rd, {24'd0, exp_cnt[a]});
        end
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic load_table();
        // len toff crc lie cut gap | len tick crc dly fault
        add_row(4, 0, 0, 0, 0, 12,   0, 0, 0, 0, 'h00);
        add_row(1, 0, 0, 0, 0, 12,   0, 0, 0, 0, 'h00);
        add_row(7, 0, 0, 0, 0, 12,   0, 0, 0, 0, 'h00);
        // Long gaps hold the delay flag and link_err up
        add_row(3, 0, 0, 0, 0, 80,   0, 0, 0, 0, 'h30);
        add_row(5, 0, 0, 0, 0, 80,   0, 0, 0, 1, 'h30);
        add_row(2, 0, 0, 0, 0, 80,   0, 0, 0, 2, 'h30);
        add_row(6, 0, 0, 0, 0, 80,   0, 0, 0, 3, 'h30);
        // Fourth episode counted so the delay flag holds
        add_row(4, 0, 0, 0, 0, 12,   0, 0, 0, 4, 'h10);
        add_row(3, 0, 1, 0, 0, 12,   0, 0, 1, 4, 'h10);
        add_row(8, 0, 1, 0, 0, 12,   0, 0, 2, 4, 'h10);
        add_row(2, 0, 1, 0, 0, 12,   0, 0, 3, 4, 'h10);
        add_row(5, 0, 1, 0, 0, 12,   0, 0, 4, 4, 'h38);
        // Tick skips
        add_row(4, 2, 0, 0, 0, 12,   0, 1, 4, 4, 'h38);
        add_row(1, 5, 0, 0, 0, 12,   0, 2, 4, 4, 'h38);
        add_row(6, 1, 0, 0, 0, 12,   0, 3, 4, 4, 'h38);
        add_row(3, 9, 0, 0, 0, 12,   0, 4, 4, 4, 'h3c);
        // Length lies then a packet cut by the next sop
        add_row(4, 0, 0, 1, 0, 12,   1, 4, 4, 4, 'h3c);
        add_row(2, 0, 0, 1, 0, 12,   2, 4, 4, 4, 'h3c);
        add_row(5, 0, 0, 1, 0, 12,   3, 4, 4, 4, 'h3c);
        add_row(3, 0, 0, 0, 1, 12,   3, 4, 4, 4, 'h3c);
        add_row(4, 0, 0, 0, 0, 12,   4, 4, 4, 4, 'h3e);
        // Good run with the clear landing on the eighth
        repeat (6) begin
            add_row(3, 0, 0, 0, 0, 12,   4, 4, 4, 4, 'h3e);
        end
        add_row(2, 0, 0, 0, 0, 12,   0, 0, 0, 0, 'h00);
        // First error after the clear still counts
        add_row(3, 0, 1, 0, 0, 12,   0, 0, 1, 0, 'h00);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_125m   = 1'b0;
        rx         = '0;
        link_break = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        load_table();
        // Bytes, gap and register checks per row
        budget = 20;
        for (int i = 0; i < num_rows; i++) begin
            budget += rows[i].len + 4 + rows[i].gap + 16;
        end
        budget += 200;
        repeat (8) @(negedge clk_125m);
        rst_125m = 1'b1;
        @(negedge clk_125m);
        compare_value("link_err", -1, {31'd0, link_err}, 32'd0);
        compare_value("wb_ack", -1, {31'd0, wb_ack}, 32'd0);
        compare_value("delay_err", -1, {31'd0, u_slink_monitor_top.delay_err}, 32'd0);
        compare_value("pkt_done", -1, {31'd0, u_slink_monitor_top.pkt_status.done}, 32'd0);
        for (int i = 0; i < num_rows; i++) begin
            send_packet(rows[i]);
            repeat (rows[i].gap) @(negedge clk_125m);
            check_row(i, rows[i]);
        end
        check_link_break();
        check_bus_map();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk_125m);
        $display("Timeout: run still busy after %0d cycles, errors so far %0d", budget, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
source/slink_pkg.sv
source/slink_crc8.sv
source/slink_rx_fsm.sv
source/slink_gap_timer.sv
source/slink_diag.sv
source/slink_wb_regs.sv
source/slink_monitor_top.sv
bench/slink_monitor_tb.sv
